// File: build.f
+incdir+sim
design/cpu_pkg.sv
design/cpu_ifs.sv
design/control_unit.sv
design/register_file.sv
design/alu.sv
design/pc_counter.sv
design/hazard_unit.sv
design/datapath.sv
sim/datapath_tb.sv

// File: Makefile
# Verilator build for the pipelined core testbench
# exit status of the simulation binary is the pass or fail result

VERILATOR  ?= verilator
TOP        := datapath_tb
FILELIST   := build.f
OBJ_DIR    := obj_dir
COMMON     := --timescale 1ns/10ps --top-module $(TOP) -f $(FILELIST)
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary -j 0 --Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(COMMON)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(COMMON)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: sim/tb_ref_model.svh
/*
 instruction encoders and a sequential reference model of the core
 included inside the testbench module, works on its imem array and store queues
*/

`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// rtype: fn rd, rs, rt (sll uses sh)
function automatic cpu_pkg::word_t enc_r(input cpu_pkg::funct_t fn, input int rd,
                                         input int rs, input int rt, input int sh);
   return {cpu_pkg::OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
endfunction

// itype: op rt, rs, imm
function automatic cpu_pkg::word_t enc_i(input cpu_pkg::opcode_t op, input int rt,
                                         input int rs, input int imm);
   return {op, rs[4:0], rt[4:0], imm[15:0]};
endfunction

function automatic cpu_pkg::word_t enc_halt();
   return {cpu_pkg::OP_HALT, 26'd0};
endfunction

////////////////////////////////////////////////////////////////////////
// in-order execution up to halt, fills exp_addr / exp_data
////////////////////////////////////////////////////////////////////////
function automatic void run_reference();
   cpu_pkg::word_t   regs [32];
   cpu_pkg::word_t   mem [256];
   cpu_pkg::word_t   ins, a, b, simm, zimm, ea;
   cpu_pkg::regsel_t rs, rt, rd;
   int               pc;
   for (int i = 0; i < 32; i++) regs[i[4:0]] = '0;
   for (int i = 0; i < 256; i++) mem[i[7:0]] = fill_word(i[7:0]);   // same start as dmem
   exp_addr.delete();
   exp_data.delete();
   pc = 0;
   while (pc < 256) begin
      ins  = imem[pc[7:0]];
      pc++;
      rs   = ins[25:21];
      rt   = ins[20:16];
      rd   = ins[15:11];
      a    = regs[rs];
      b    = regs[rt];
      simm = {{16{ins[15]}}, ins[15:0]};
      zimm = {16'h0000, ins[15:0]};          // ori only
      ea   = a + simm;
      if (ins[31:26] == cpu_pkg::OP_HALT) break;
      case (ins[31:26])
         cpu_pkg::OP_RTYPE: begin
            case (ins[5:0])
               cpu_pkg::FN_ADDU: regs[rd] = a + b;
               cpu_pkg::FN_SUBU: regs[rd] = a - b;
               cpu_pkg::FN_AND:  regs[rd] = a & b;
               cpu_pkg::FN_OR:   regs[rd] = a | b;
               cpu_pkg::FN_XOR:  regs[rd] = a ^ b;
               cpu_pkg::FN_SLT:  regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
               cpu_pkg::FN_SLL:  regs[rd] = b << ins[10:6];
               default: ;
            endcase
         end
         cpu_pkg::OP_ADDIU: regs[rt] = a + simm;
         cpu_pkg::OP_ORI:   regs[rt] = a | zimm;
         cpu_pkg::OP_LUI:   regs[rt] = {ins[15:0], 16'h0000};
         cpu_pkg::OP_LW:    regs[rt] = mem[ea[9:2]];
         cpu_pkg::OP_SW: begin
            mem[ea[9:2]] = b;
            exp_addr.push_back(ea);
            exp_data.push_back(b);
         end
         default: ;
      endcase
      regs[0] = '0;                          // $0 pinned
   end
endfunction

`endif

// File: sim/datapath_tb.sv
/*
 testbench for the pipelined core with random-latency memories around the DUT
 runs a directed and a random program and checks every store against the reference
*/

`timescale 1ns/10ps

module datapath_tb;

   logic           clk;
   logic           rst       = 1'b1;
   logic           imem_ren;
   cpu_pkg::word_t imem_addr;
   cpu_pkg::word_t imem_load = '0;
   logic           ihit      = 1'b0;
   logic           dmem_ren, dmem_wen;
   cpu_pkg::word_t dmem_addr, dmem_store;
   cpu_pkg::word_t dmem_load = '0;
   logic           dhit      = 1'b0;
   logic           halt;

   cpu_pkg::word_t imem [256];          // word addressed by addr[9:2]
   cpu_pkg::word_t dmem [256];
   cpu_pkg::word_t exp_addr [$];        // expected stores in program order
   cpu_pkg::word_t exp_data [$];
   cpu_pkg::word_t prog_state = 32'ha44ebb0d;
   cpu_pkg::word_t lat_state  = 32'ha44ebb0d;
   int   n_instr     = 0;
   int   store_cnt   = 0;
   int   cycles      = 0;
   int   cycle_limit = 200;
   int   i_wait      = -1;              // -1 means draw a new latency
   int   d_wait      = -1;
   logic running     = 1'b0;
   logic in_reset;

   datapath datapath_i (
      .CLK(clk), .rst(rst),
      .imem_ren(imem_ren), .imem_addr(imem_addr), .imem_load(imem_load), .ihit(ihit),
      .dmem_ren(dmem_ren), .dmem_wen(dmem_wen), .dmem_addr(dmem_addr),
      .dmem_store(dmem_store), .dmem_load(dmem_load), .dhit(dhit), .halt(halt)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic cpu_pkg::word_t lcg_next(input cpu_pkg::word_t s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // power-on data memory contents
   function automatic cpu_pkg::word_t fill_word(input logic [7:0] idx);
      cpu_pkg::word_t a;
      a = {22'd0, idx, 2'b00};
      return {~a[15:0], a[15:0]} ^ 32'h3c5a_0f1e;
   endfunction

   `include "tb_ref_model.svh"

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("TESTBENCH FAILED");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_word(input string name, input cpu_pkg::word_t got,
                             input cpu_pkg::word_t exp);
      if (got !== exp)
         stop_on_error($sformatf("mismatch at %0t: %s got %h expected %h",
                                 $time, name, got, exp));
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
         stop_on_error($sformatf("mismatch at %0t: %s got %b expected %b",
                                 $time, name, got, exp));
   endtask

   //////////////////////////////////////////////////////////////////////
   // program building
   //////////////////////////////////////////////////////////////////////
   task automatic clear_program();
      for (int i = 0; i < 256; i++) imem[i[7:0]] = 32'h0000_0000;   // nops
      n_instr = 0;
   endtask

   task automatic emit(input cpu_pkg::word_t w);
      imem[n_instr[7:0]] = w;
      n_instr++;
   endtask

   // r picks kind and registers and s the immediate
   function automatic cpu_pkg::word_t random_instr(input cpu_pkg::word_t r,
                                                   input cpu_pkg::word_t s);
      int d, a, b, off;
      d   = int'(r[19:16]);                 // $0..$15
      a   = int'(r[23:20]);
      b   = int'(r[27:24]);
      off = int'({s[9:2], 2'b00});          // stays inside dmem with base $0
      case (r[31:28])
         4'd0: return enc_r(cpu_pkg::FN_ADDU, d, a, b, 0);
         4'd1: return enc_r(cpu_pkg::FN_SUBU, d, a, b, 0);
         4'd2: return enc_r(cpu_pkg::FN_AND, d, a, b, 0);
         4'd3: return enc_r(cpu_pkg::FN_OR, d, a, b, 0);
         4'd4: return enc_r(cpu_pkg::FN_XOR, d, a, b, 0);
         4'd5: return enc_r(cpu_pkg::FN_SLT, d, a, b, 0);
         4'd6: return enc_r(cpu_pkg::FN_SLL, d, 0, b, int'(s[4:0]));
         4'd7, 4'd8: return enc_i(cpu_pkg::OP_ADDIU, d, a, int'(s[31:16]));
         4'd9:  return enc_i(cpu_pkg::OP_ORI, d, a, int'(s[31:16]));
         4'd10: return enc_i(cpu_pkg::OP_LUI, d, 0, int'(s[31:16]));
         4'd11, 4'd12: return enc_i(cpu_pkg::OP_LW, d, 0, off);
         default: return enc_i(cpu_pkg::OP_SW, b, 0, off);
      endcase
   endfunction

   task automatic load_directed();
      clear_program();
      emit(enc_i(cpu_pkg::OP_LUI, 1, 0, 'h8000));      // 0x80000000
      emit(enc_i(cpu_pkg::OP_ORI, 1, 1, 'h0001));      // back to back on $1
      emit(enc_i(cpu_pkg::OP_ADDIU, 2, 0, -1));        // sign extended
      emit(enc_i(cpu_pkg::OP_ORI, 3, 0, 'hffff));      // zero extended
      emit(enc_r(cpu_pkg::FN_ADDU, 4, 1, 2, 0));       // wraps
      emit(enc_r(cpu_pkg::FN_SUBU, 5, 0, 1, 0));
      emit(enc_r(cpu_pkg::FN_AND, 6, 1, 3, 0));
      emit(enc_r(cpu_pkg::FN_OR, 7, 2, 3, 0));
      emit(enc_r(cpu_pkg::FN_XOR, 8, 1, 3, 0));
      emit(enc_r(cpu_pkg::FN_SLT, 9, 1, 3, 0));        // negative < positive
      emit(enc_r(cpu_pkg::FN_SLT, 10, 3, 1, 0));
      emit(enc_r(cpu_pkg::FN_SLL, 11, 0, 3, 12));
      emit(enc_i(cpu_pkg::OP_ADDIU, 0, 3, 5));         // $0 target is dropped
      emit(enc_i(cpu_pkg::OP_ADDIU, 12, 2, 'h7fff));
      emit(enc_i(cpu_pkg::OP_LW, 13, 0, 'h40));
      emit(enc_r(cpu_pkg::FN_ADDU, 14, 13, 13, 0));    // load use
      for (int r = 0; r < 15; r++) emit(enc_i(cpu_pkg::OP_SW, r, 0, 'h100 + 4 * r));
      emit(enc_i(cpu_pkg::OP_LW, 15, 0, 'h104));       // reads a fresh store
      emit(enc_i(cpu_pkg::OP_SW, 15, 0, 'h200));
      emit(enc_halt());
      emit(enc_i(cpu_pkg::OP_SW, 1, 0, 'h300));        // younger than halt
      emit(enc_i(cpu_pkg::OP_SW, 2, 0, 'h304));
   endtask

   task automatic load_random(input int count);
      cpu_pkg::word_t r, s;
      clear_program();
      for (int k = 0; k < count; k++) begin
         prog_state = lcg_next(prog_state);
         r          = prog_state;
         prog_state = lcg_next(prog_state);
         s          = prog_state;
         emit(random_instr(r, s));
      end
      emit(enc_halt());
   endtask

   // reset, run to halt, then watch a few more cycles
   task automatic run_program();
      run_reference();
      cycle_limit = 40 * n_instr + 200;
      @(posedge clk);
      #2;
      rst = 1'b1;
      repeat (8) @(posedge clk);
      #2;
      rst     = 1'b0;
      running = 1'b1;
      @(negedge clk);                          // ports still show the reset state
      check_bit("halt", halt, 1'b0);
      check_bit("imem_ren", imem_ren, 1'b1);
      check_word("imem_addr", imem_addr, 32'h0000_0000);
      check_bit("dmem_ren", dmem_ren, 1'b0);
      check_bit("dmem_wen", dmem_wen, 1'b0);
      do @(negedge clk); while (halt !== 1'b1);
      repeat (10) begin
         @(negedge clk);
         check_bit("halt", halt, 1'b1);
         check_bit("imem_ren", imem_ren, 1'b0);   // no fetch once halted
         check_bit("dmem_ren", dmem_ren, 1'b0);
         check_bit("dmem_wen", dmem_wen, 1'b0);
      end
      check_word("store_cnt", store_cnt, exp_addr.size());
      running = 1'b0;
   endtask

   //////////////////////////////////////////////////////////////////////
   // memory models with 0 to 3 wait cycles per access
   //////////////////////////////////////////////////////////////////////
   always @(posedge clk) begin
      in_reset = rst;                        // level the DUT just sampled
      #2;
      if (in_reset || !imem_ren) begin
         ihit   = 1'b0;
         i_wait = -1;
      end else begin
         if (i_wait < 0) begin
            lat_state = lcg_next(lat_state);
            i_wait    = int'(lat_state[31:30]);
         end
         if (i_wait == 0) begin
            ihit      = 1'b1;
            imem_load = imem[imem_addr[9:2]];
            i_wait    = -1;
         end else begin
            ihit = 1'b0;
            i_wait--;
         end
      end
      if (in_reset) begin
         for (int i = 0; i < 256; i++) dmem[i[7:0]] = fill_word(i[7:0]);
         dhit   = 1'b0;
         d_wait = -1;
      end else if (!(dmem_ren || dmem_wen)) begin
         dhit   = 1'b0;
         d_wait = -1;
      end else begin
         if (d_wait < 0) begin
            lat_state = lcg_next(lat_state);
            d_wait    = int'(lat_state[31:30]);
         end
         if (d_wait == 0) begin
            dhit = 1'b1;                     // request done this cycle
            if (dmem_wen) dmem[dmem_addr[9:2]] = dmem_store;
            else dmem_load = dmem[dmem_addr[9:2]];
            d_wait = -1;
         end else begin
            dhit = 1'b0;
            d_wait--;
         end
      end
   end

   // store checker samples mid cycle
   always @(negedge clk) begin
      if (rst) begin
         store_cnt = 0;
      end else if (dmem_wen && dhit) begin
         if (store_cnt >= exp_addr.size()) begin
            stop_on_error("the DUT made a store that the reference program never makes");
         end else begin
            check_word("dmem_addr", dmem_addr, exp_addr[store_cnt]);
            check_word("dmem_store", dmem_store, exp_data[store_cnt]);
            store_cnt++;
         end
      end
   end

   always @(posedge clk) begin
      cycles = running ? cycles + 1 : 0;
      if (cycles > cycle_limit)
         stop_on_error($sformatf("the run timed out after %0d cycles without halt", cycles));
   end

   initial begin
      load_directed();
      run_program();
      load_random(60);
      run_program();
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

// File: design/datapath.sv
/*
 top level of the pipelined core with the four stage latches and operand muxes
 drives the instruction and data memory ports from the pc and the em record
*/

`timescale 1ns/10ps

module datapath (
   input  logic           CLK,
   input  logic           rst,
   // instruction memory
   output logic           imem_ren,
   output cpu_pkg::word_t imem_addr,
   input  cpu_pkg::word_t imem_load,
   input  logic           ihit,
   // data memory
   output logic           dmem_ren,
   output logic           dmem_wen,
   output cpu_pkg::word_t dmem_addr,
   output cpu_pkg::word_t dmem_store,
   input  cpu_pkg::word_t dmem_load,
   input  logic           dhit,
   output logic           halt
);

   regfile_if rfif ();
   hazard_if  hzif ();

   // stage latches and their next values
   cpu_pkg::fd_rec_t fd, fd_in;
   cpu_pkg::de_rec_t de, de_in;
   cpu_pkg::em_rec_t em, em_in;
   cpu_pkg::mw_rec_t mw, mw_in;

   cpu_pkg::word_t    pc;
   cpu_pkg::word_t    dec_instr;
   cpu_pkg::regsel_t  cu_rs, cu_rt, cu_dest;
   logic              cu_rs_used, cu_rt_used, cu_sign_ext;
   logic              cu_reg_wr, cu_load, cu_store, cu_halt;
   logic [4:0]        cu_shamt;
   cpu_pkg::imm16_t   cu_imm;
   cpu_pkg::alu_src_t cu_alu_src;
   cpu_pkg::alu_op_t  cu_alu_op;
   cpu_pkg::word_t    op1, op2, alu_res;

   //////////////////////////////////////////////////////////////////////
   // blocks
   //////////////////////////////////////////////////////////////////////
   control_unit cu_i (
      .instr(dec_instr), .rs(cu_rs), .rt(cu_rt), .rd(),
      .rs_used(cu_rs_used), .rt_used(cu_rt_used), .shamt(cu_shamt),
      .imm(cu_imm), .sign_ext(cu_sign_ext), .alu_src_sel(cu_alu_src),
      .alu_op(cu_alu_op), .dest(cu_dest), .reg_wr(cu_reg_wr),
      .load(cu_load), .store(cu_store), .halt(cu_halt)
   );
   register_file rf_i (.CLK(CLK), .rst(rst), .rf(rfif.rf));
   alu alu_i (.op1(op1), .op2(op2), .shamt(de.shamt), .op(de.alu_op), .res(alu_res));
   pc_counter pc_i (.CLK(CLK), .rst(rst), .en(hzif.pc_en), .pc(pc));
   hazard_unit hz_i (.CLK(CLK), .rst(rst), .hz(hzif.hz));

   // memory ports
   assign imem_ren   = ~hzif.halted;
   assign imem_addr  = pc;
   assign dmem_ren   = em.valid & em.load;     // held while em holds
   assign dmem_wen   = em.valid & em.store;
   assign dmem_addr  = em.alu_res;
   assign dmem_store = em.store_dat;
   assign halt       = hzif.halted;

   // hazard unit inputs where bubbles never count
   assign hzif.ihit      = ihit;
   assign hzif.dhit      = dhit;
   assign hzif.mem_req   = dmem_ren | dmem_wen;
   assign hzif.rs        = cu_rs;
   assign hzif.rt        = cu_rt;
   assign hzif.rs_used   = cu_rs_used;
   assign hzif.rt_used   = cu_rt_used;
   assign hzif.de_dest   = de.dest;
   assign hzif.de_reg_wr = de.valid & de.reg_wr;
   assign hzif.em_dest   = em.dest;
   assign hzif.em_reg_wr = em.valid & em.reg_wr;
   assign hzif.em_halt   = em.valid & em.halt;
   assign hzif.mw_halt   = mw.valid & mw.halt;

   //////////////////////////////////////////////////////////////////////
   // fetch and decode
   //////////////////////////////////////////////////////////////////////
   assign fd_in.instr = imem_load;
   assign fd_in.pc    = pc;
   assign fd_in.valid = ihit;                  // a miss loads a bubble

   assign dec_instr = fd.valid ? fd.instr : cpu_pkg::NOP_WORD;

   assign rfif.rsel1 = cu_rs;
   assign rfif.rsel2 = cu_rt;

   assign de_in.rdat1   = rfif.rdat1;
   assign de_in.rdat2   = rfif.rdat2;
   assign de_in.imm_ext = cu_sign_ext ? {{16{cu_imm[15]}}, cu_imm} : {16'h0000, cu_imm};
   assign de_in.shamt   = cu_shamt;
   assign de_in.alu_op  = cu_alu_op;
   assign de_in.alu_src = cu_alu_src;
   assign de_in.dest    = cu_dest;
   assign de_in.reg_wr  = cu_reg_wr;
   assign de_in.load    = cu_load;
   assign de_in.store   = cu_store;
   assign de_in.halt    = cu_halt;
   assign de_in.valid   = fd.valid;

   // execute operands
   always_comb begin
      op1 = de.rdat1;
      case (de.alu_src)
         cpu_pkg::SRC_IMM: op2 = de.imm_ext;
         cpu_pkg::SRC_LUI: begin
            op1 = '0;                           // lui ignores rs
            op2 = {de.imm_ext[15:0], 16'h0000};
         end
         default: op2 = de.rdat2;
      endcase
   end

   // a halt in em squashes whatever follows it out of de
   assign em_in.alu_res   = alu_res;
   assign em_in.store_dat = de.rdat2;
   assign em_in.dest      = de.dest;
   assign em_in.reg_wr    = de.reg_wr & ~em.halt;
   assign em_in.load      = de.load & ~em.halt;
   assign em_in.store     = de.store & ~em.halt;
   assign em_in.halt      = de.halt & ~em.halt;
   assign em_in.valid     = de.valid & ~em.halt;

   //////////////////////////////////////////////////////////////////////
   // memory and writeback
   //////////////////////////////////////////////////////////////////////
   assign mw_in.alu_res  = em.alu_res;
   assign mw_in.load_dat = dmem_load;          // sampled on the dhit edge
   assign mw_in.dest     = em.dest;
   assign mw_in.reg_wr   = em.reg_wr;
   assign mw_in.load     = em.load;
   assign mw_in.halt     = em.halt;
   assign mw_in.valid    = em.valid;

   assign rfif.wsel = mw.dest;
   assign rfif.wen  = mw.valid & mw.reg_wr;
   assign rfif.wdat = mw.load ? mw.load_dat : mw.alu_res;

   // stage latches
   always_ff @(posedge CLK) begin
      if (rst) begin
         fd <= '0;
         de <= '0;
         em <= '0;
         mw <= '0;
      end else begin
         if (hzif.fd_en) fd <= fd_in;
         if (hzif.de_flush) de <= '0;          // bubble
         else if (hzif.de_en) de <= de_in;
         if (hzif.em_en) em <= em_in;
         if (hzif.mw_en) mw <= mw_in;
      end
   end

endmodule

// File: design/hazard_unit.sv
/*
 pipeline control, turns memory waits, RAW hazards, fetch misses and halt
 into latch enables, the de flush and the pc enable
*/

`timescale 1ns/10ps

module hazard_unit (
   input logic  CLK,
   input logic  rst,
   hazard_if.hz hz
);

   cpu_pkg::hz_state_t state, next_state;

   logic mem_stall;    // data port busy, freeze everything
   logic rs_hit, rt_hit;
   logic data_hz;
   logic stop_fetch;   // halt in flight, nothing younger enters decode

   //////////////////////////////////////////////////////////////////////
   // hazard detection
   //////////////////////////////////////////////////////////////////////
   assign mem_stall = hz.mem_req & ~hz.dhit;

   // $0 never counts as a real destination
   assign rs_hit = hz.rs_used && hz.rs != 5'd0 &&
                   ((hz.de_reg_wr && hz.de_dest == hz.rs) ||
                    (hz.em_reg_wr && hz.em_dest == hz.rs));
   assign rt_hit = hz.rt_used && hz.rt != 5'd0 &&
                   ((hz.de_reg_wr && hz.de_dest == hz.rt) ||
                    (hz.em_reg_wr && hz.em_dest == hz.rt));
   assign data_hz    = rs_hit | rt_hit;
   assign stop_fetch = hz.em_halt | hz.mw_halt;

   //////////////////////////////////////////////////////////////////////
   // state
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge CLK) begin
      if (rst) state <= cpu_pkg::HZ_RUN;
      else     state <= next_state;
   end

   always_comb begin
      case (state)
         cpu_pkg::HZ_HALTED: next_state = cpu_pkg::HZ_HALTED;   // until reset
         default: begin
            if (hz.mw_halt)     next_state = cpu_pkg::HZ_HALTED;
            else if (mem_stall) next_state = cpu_pkg::HZ_DWAIT;
            else                next_state = cpu_pkg::HZ_RUN;
         end
      endcase
   end

   assign hz.halted = (state == cpu_pkg::HZ_HALTED);

   // enables
   always_comb begin
      hz.fd_en    = 1'b0;
      hz.de_en    = 1'b0;
      hz.em_en    = 1'b0;
      hz.mw_en    = 1'b0;
      hz.de_flush = 1'b0;
      hz.pc_en    = 1'b0;
      if (!hz.halted && !mem_stall) begin
         hz.em_en = 1'b1;
         hz.mw_en = 1'b1;
         hz.de_en = 1'b1;
         if (data_hz || stop_fetch) begin
            hz.de_flush = 1'b1;      // bubble into execute, fd and pc hold
         end else begin
            hz.fd_en = 1'b1;         // fd takes a bubble on a miss
            hz.pc_en = hz.ihit;
         end
      end
   end

endmodule

// File: design/pc_counter.sv
/*
 program counter, steps one word per enabled cycle
*/

`timescale 1ns/10ps

module pc_counter (
   input  logic           CLK,
   input  logic           rst,
   input  logic           en,
   output cpu_pkg::word_t pc
);

   always_ff @(posedge CLK) begin
      if (rst) begin
         pc <= cpu_pkg::PC_INIT;
      end else if (en) begin
         pc <= pc + 32'd4;   // no branches, always sequential
      end
   end

endmodule

// File: design/alu.sv
/*
 execute stage ALU, all results wrap at 32 bits
*/

`timescale 1ns/10ps

module alu (
   input  cpu_pkg::word_t   op1,
   input  cpu_pkg::word_t   op2,
   input  logic [4:0]       shamt,
   input  cpu_pkg::alu_op_t op,
   output cpu_pkg::word_t   res
);

   logic lt;   // signed less-than

   assign lt = $signed(op1) < $signed(op2);

   always_comb begin
      case (op)
         cpu_pkg::ALU_ADD: res = op1 + op2;
         cpu_pkg::ALU_SUB: res = op1 - op2;
         cpu_pkg::ALU_AND: res = op1 & op2;
         cpu_pkg::ALU_OR:  res = op1 | op2;
         cpu_pkg::ALU_XOR: res = op1 ^ op2;
         cpu_pkg::ALU_SLT: res = {31'd0, lt};
         cpu_pkg::ALU_SLL: res = op2 << shamt;   // rt shifted, rs unused
         default:          res = op1 + op2;
      endcase
   end

endmodule

// File: design/register_file.sv
/*
 32x32 register file, $0 reads zero
 a write shows up on same-cycle reads of that register
*/

`timescale 1ns/10ps

module register_file (
   input logic   CLK,
   input logic   rst,
   regfile_if.rf rf
);

   cpu_pkg::word_t regs [32];

   always_ff @(posedge CLK) begin
      if (rst) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (rf.wen && rf.wsel != 5'd0) begin   // $0 never written
         regs[rf.wsel] <= rf.wdat;
      end
   end

   // write-through, so writeback never stalls decode
   assign rf.rdat1 = (rf.wen && rf.wsel != 5'd0 && rf.wsel == rf.rsel1) ?
                     rf.wdat : regs[rf.rsel1];
   assign rf.rdat2 = (rf.wen && rf.wsel != 5'd0 && rf.wsel == rf.rsel2) ?
                     rf.wdat : regs[rf.rsel2];

endmodule

// File: design/control_unit.sv
/*
 instruction decoder, turns the fd instruction word into stage controls
 anything unrecognized comes out as a no-op
*/

`timescale 1ns/10ps

module control_unit (
   input  cpu_pkg::word_t    instr,
   output cpu_pkg::regsel_t  rs,
   output cpu_pkg::regsel_t  rt,
   output cpu_pkg::regsel_t  rd,
   output logic              rs_used,
   output logic              rt_used,
   output logic [4:0]        shamt,
   output cpu_pkg::imm16_t   imm,
   output logic              sign_ext,
   output cpu_pkg::alu_src_t alu_src_sel,
   output cpu_pkg::alu_op_t  alu_op,
   output cpu_pkg::regsel_t  dest,
   output logic              reg_wr,
   output logic              load,
   output logic              store,
   output logic              halt
);

   cpu_pkg::opcode_t op;
   cpu_pkg::funct_t  fn;

   // raw fields
   assign op    = instr[31:26];
   assign fn    = instr[5:0];
   assign rs    = instr[25:21];
   assign rt    = instr[20:16];
   assign rd    = instr[15:11];
   assign shamt = instr[10:6];
   assign imm   = instr[15:0];

   always_comb begin
      // no-op defaults
      rs_used     = 1'b0;
      rt_used     = 1'b0;
      sign_ext    = 1'b0;
      alu_src_sel = cpu_pkg::SRC_REG;
      alu_op      = cpu_pkg::ALU_ADD;
      dest        = rt;                 // itype default
      reg_wr      = 1'b0;
      load        = 1'b0;
      store       = 1'b0;
      halt        = 1'b0;
      case (op)
         cpu_pkg::OP_RTYPE: begin
            dest    = rd;
            reg_wr  = 1'b1;
            rs_used = 1'b1;
            rt_used = 1'b1;
            case (fn)
               cpu_pkg::FN_ADDU: alu_op = cpu_pkg::ALU_ADD;
               cpu_pkg::FN_SUBU: alu_op = cpu_pkg::ALU_SUB;
               cpu_pkg::FN_AND:  alu_op = cpu_pkg::ALU_AND;
               cpu_pkg::FN_OR:   alu_op = cpu_pkg::ALU_OR;
               cpu_pkg::FN_XOR:  alu_op = cpu_pkg::ALU_XOR;
               cpu_pkg::FN_SLT:  alu_op = cpu_pkg::ALU_SLT;
               cpu_pkg::FN_SLL: begin
                  alu_op  = cpu_pkg::ALU_SLL;
                  rs_used = 1'b0;          // shifts rt only
               end
               default: begin
                  reg_wr  = 1'b0;          // unknown funct
                  rs_used = 1'b0;
                  rt_used = 1'b0;
               end
            endcase
         end
         cpu_pkg::OP_ADDIU: begin
            rs_used     = 1'b1;
            sign_ext    = 1'b1;
            alu_src_sel = cpu_pkg::SRC_IMM;
            reg_wr      = 1'b1;
         end
         cpu_pkg::OP_ORI: begin
            rs_used     = 1'b1;            // zero extended
            alu_src_sel = cpu_pkg::SRC_IMM;
            alu_op      = cpu_pkg::ALU_OR;
            reg_wr      = 1'b1;
         end
         cpu_pkg::OP_LUI: begin
            alu_src_sel = cpu_pkg::SRC_LUI;  // op1 forced to zero downstream
            reg_wr      = 1'b1;
         end
         cpu_pkg::OP_LW: begin
            rs_used     = 1'b1;
            sign_ext    = 1'b1;
            alu_src_sel = cpu_pkg::SRC_IMM;
            reg_wr      = 1'b1;
            load        = 1'b1;
         end
         cpu_pkg::OP_SW: begin
            rs_used     = 1'b1;            // base
            rt_used     = 1'b1;            // store data
            sign_ext    = 1'b1;
            alu_src_sel = cpu_pkg::SRC_IMM;
            store       = 1'b1;
         end
         cpu_pkg::OP_HALT: halt = 1'b1;
         default: ;
      endcase
   end

endmodule

// File: design/cpu_ifs.sv
/*
 register file and hazard unit interfaces used inside the datapath
*/

`timescale 1ns/10ps

interface regfile_if;
   cpu_pkg::regsel_t rsel1, rsel2;   // decode read selects
   cpu_pkg::word_t   rdat1, rdat2;
   cpu_pkg::regsel_t wsel;           // writeback side
   logic             wen;
   cpu_pkg::word_t   wdat;

   modport dp (
      output rsel1, rsel2, wsel, wen, wdat,
      input  rdat1, rdat2
   );
   modport rf (
      input  rsel1, rsel2, wsel, wen, wdat,
      output rdat1, rdat2
   );
endinterface

interface hazard_if;
   // memory status
   logic ihit, dhit;
   logic mem_req;                    // em record wants the data port
   // decode sources vs. older destinations
   cpu_pkg::regsel_t rs, rt;
   logic             rs_used, rt_used;
   cpu_pkg::regsel_t de_dest, em_dest;
   logic             de_reg_wr, em_reg_wr;
   logic             em_halt, mw_halt;
   // latch control back to the datapath
   logic fd_en, de_en, em_en, mw_en;
   logic de_flush;
   logic pc_en;
   logic halted;

   modport dp (
      output ihit, dhit, mem_req, rs, rt, rs_used, rt_used,
             de_dest, em_dest, de_reg_wr, em_reg_wr, em_halt, mw_halt,
      input  fd_en, de_en, em_en, mw_en, de_flush, pc_en, halted
   );
   modport hz (
      input  ihit, dhit, mem_req, rs, rt, rs_used, rt_used,
             de_dest, em_dest, de_reg_wr, em_reg_wr, em_halt, mw_halt,
      output fd_en, de_en, em_en, mw_en, de_flush, pc_en, halted
   );
endinterface

// File: design/cpu_pkg.sv
/*
 shared widths, encodings and pipeline records for the five-stage core
 compile first, every other file refers to it by scoped names
*/

package cpu_pkg;

   // widths with a meaning
   typedef logic [31:0] word_t;     // data or address word
   typedef logic [4:0]  regsel_t;   // register number
   typedef logic [15:0] imm16_t;    // immediate field
   typedef logic [5:0]  opcode_t;   // instr[31:26]
   typedef logic [5:0]  funct_t;    // instr[5:0]

   localparam word_t PC_INIT  = 32'h0000_0000;
   localparam word_t NOP_WORD = 32'h0000_0000;   // sll $0,$0,0

   // major opcodes
   localparam opcode_t OP_RTYPE = 6'h00;
   localparam opcode_t OP_ADDIU = 6'h09;
   localparam opcode_t OP_ORI   = 6'h0d;
   localparam opcode_t OP_LUI   = 6'h0f;
   localparam opcode_t OP_LW    = 6'h23;
   localparam opcode_t OP_SW    = 6'h2b;
   localparam opcode_t OP_HALT  = 6'h3f;

   // rtype function codes
   localparam funct_t FN_SLL  = 6'h00;
   localparam funct_t FN_ADDU = 6'h21;
   localparam funct_t FN_SUBU = 6'h23;
   localparam funct_t FN_AND  = 6'h24;
   localparam funct_t FN_OR   = 6'h25;
   localparam funct_t FN_XOR  = 6'h26;
   localparam funct_t FN_SLT  = 6'h2a;

   typedef enum logic [2:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL
   } alu_op_t;

   // second alu operand
   typedef enum logic [1:0] {SRC_REG, SRC_IMM, SRC_LUI} alu_src_t;

   typedef enum logic [1:0] {HZ_RUN, HZ_DWAIT, HZ_HALTED} hz_state_t;

   ////////////////////////////////////////////////////////////////////
   // pipeline records
   ////////////////////////////////////////////////////////////////////
   typedef struct packed {
      word_t instr;
      word_t pc;        // fetch address
      logic  valid;
   } fd_rec_t;

   typedef struct packed {
      word_t    rdat1;
      word_t    rdat2;
      word_t    imm_ext;   // zero or sign extended
      logic [4:0] shamt;
      alu_op_t  alu_op;
      alu_src_t alu_src;
      regsel_t  dest;
      logic     reg_wr;
      logic     load;
      logic     store;
      logic     halt;
      logic     valid;
   } de_rec_t;

   typedef struct packed {
      word_t   alu_res;    // also the data address
      word_t   store_dat;
      regsel_t dest;
      logic    reg_wr;
      logic    load;
      logic    store;
      logic    halt;
      logic    valid;
   } em_rec_t;

   typedef struct packed {
      word_t   alu_res;
      word_t   load_dat;
      regsel_t dest;
      logic    reg_wr;
      logic    load;     // picks load_dat for writeback
      logic    halt;
      logic    valid;
   } mw_rec_t;

endpackage
